// ==== alu_pkg.sv ====
package alu_pkg;

    // ALU operation codes as encoded in the select field
    typedef enum logic [2:0] {
        op_mov = 3'd0,
        op_add = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_mul = 3'd4,
        op_lsh = 3'd5,
        op_ash = 3'd6,
        op_rot = 3'd7
    } alu_op_t;

    // Operand width must be a power of two and at least 4
    localparam int DEFAULT_DATA_WIDTH = 8;

    // Result FIFO entries and initial requester credits
    localparam int DEFAULT_QUEUE_DEPTH = 4;

    // Credits granted by the consumer out of reset
    localparam int DEFAULT_OUT_CREDITS = 2;

endpackage

// ==== alu_req_if.sv ====
`timescale 1ns/10ps

interface alu_req_if #(
    parameter int DATA_WIDTH = alu_pkg::DEFAULT_DATA_WIDTH
);
    import alu_pkg::*;

    // One-cycle request strobe
    logic                  valid;
    alu_op_t               op;
    // data1 is the value operated on, data2 the second operand or shift amount
    logic [DATA_WIDTH-1:0] data1;
    logic [DATA_WIDTH-1:0] data2;

    modport src (
        output valid,
        output op,
        output data1,
        output data2
    );

    modport sink (
        input valid,
        input op,
        input data1,
        input data2
    );

endinterface

// ==== alu_shifter.sv ====
`timescale 1ns/10ps

module alu_shifter #(
    parameter int DATA_WIDTH = alu_pkg::DEFAULT_DATA_WIDTH
) (
    input  alu_pkg::alu_op_t      op,
    input  logic [DATA_WIDTH-1:0] data,
    input  logic [DATA_WIDTH-1:0] amount,
    output logic [DATA_WIDTH-1:0] result
);
    import alu_pkg::*;

    localparam int LOG_W = $clog2(DATA_WIDTH);

    logic                           is_rot;
    logic                           is_ash;
    logic                           neg;
    logic                           sign;
    logic                           sat;
    logic [DATA_WIDTH-1:0]          mag;
    logic [LOG_W:0][DATA_WIDTH-1:0] ls;
    logic [LOG_W:0][DATA_WIDTH-1:0] rs;
    logic [DATA_WIDTH-1:0]          shifted;

    assign is_rot = (op == op_rot);
    assign is_ash = (op == op_ash);
    assign sign   = data[DATA_WIDTH-1];

    // Negative amount means shift right by its magnitude
    assign neg = amount[DATA_WIDTH-1];
    assign mag = neg ? (~amount + 1'b1) : amount;

    // Magnitude of DATA_WIDTH or more
    assign sat = |mag[DATA_WIDTH-1:LOG_W];

    assign ls[0] = data;
    assign rs[0] = data;

    // Layer k moves by 2**k when magnitude bit k is set
    for (genvar k = 0; k < LOG_W; k++) begin : g_layer
        localparam int STEP = 1 << k;

        for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_bit
            logic l_in;
            logic r_in;

            if (i >= STEP) begin : g_l_inner
                assign l_in = ls[k][i-STEP];
            end else begin : g_l_fill
                // Top bits wrap around for rotate
                assign l_in = is_rot ? ls[k][i-STEP+DATA_WIDTH] : 1'b0;
            end

            if (i + STEP < DATA_WIDTH) begin : g_r_inner
                assign r_in = rs[k][i+STEP];
            end else begin : g_r_fill
                assign r_in = is_rot ? rs[k][i+STEP-DATA_WIDTH] : (is_ash & sign);
            end

            if (i == DATA_WIDTH - 1) begin : g_l_msb
                // Arithmetic left shift holds the sign bit in place
                assign ls[k+1][i] = (mag[k] && !is_ash) ? l_in : ls[k][i];
            end else begin : g_l_low
                assign ls[k+1][i] = mag[k] ? l_in : ls[k][i];
            end

            assign rs[k+1][i] = mag[k] ? r_in : rs[k][i];
        end
    end

    assign shifted = neg ? rs[LOG_W] : ls[LOG_W];

    // Out-of-range shifts saturate unless the op is rotate
    always_comb begin
        if (sat && !is_rot) begin
            if (!is_ash) begin
                result = '0;
            end else if (neg) begin
                result = {DATA_WIDTH{sign}};
            end else begin
                result = {sign, {(DATA_WIDTH-1){1'b0}}};
            end
        end else begin
            result = shifted;
        end
    end

endmodule

// ==== alu_multiplier.sv ====
`timescale 1ns/10ps

module alu_multiplier #(
    parameter int DATA_WIDTH = alu_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic [DATA_WIDTH-1:0] data1,
    input  logic [DATA_WIDTH-1:0] data2,
    output logic [DATA_WIDTH-1:0] product
);

    // Running partial sum after each row truncated to DATA_WIDTH bits
    logic [DATA_WIDTH-1:0][DATA_WIDTH-1:0] acc;

    assign acc[0] = data1 & {DATA_WIDTH{data2[0]}};

    for (genvar j = 1; j < DATA_WIDTH; j++) begin : g_row
        logic [DATA_WIDTH-1:0] c;

        assign c[0] = 1'b0;

        for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_col
            if (i < j) begin : g_pass
                // Nothing added below the row offset
                assign acc[j][i] = acc[j-1][i];
                assign c[i+1]    = 1'b0;
            end else begin : g_fa
                logic pp;

                assign pp        = data2[j] & data1[i-j];
                assign acc[j][i] = acc[j-1][i] ^ pp ^ c[i];
                // Carry out of the top bit is dropped
                if (i < DATA_WIDTH - 1) begin : g_cout
                    assign c[i+1] = (acc[j-1][i] & pp) | (c[i] & (acc[j-1][i] ^ pp));
                end
            end
        end
    end

    assign product = acc[DATA_WIDTH-1];

endmodule

// ==== alu_execute.sv ====
`timescale 1ns/10ps

module alu_execute #(
    parameter int DATA_WIDTH = alu_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    alu_req_if.sink               req,
    output logic                  res_valid,
    output logic [DATA_WIDTH-1:0] res_data,
    output logic                  res_zero
);
    import alu_pkg::*;

    logic [DATA_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0] shift_res;
    logic [DATA_WIDTH-1:0] mul_res;
    logic [DATA_WIDTH-1:0] result;

    // Subtraction comes in as the two's complement of data2
    assign sum = req.data1 + req.data2;

    alu_shifter #(
        .DATA_WIDTH (DATA_WIDTH)
    ) shifter0 (
        .op     (req.op),
        .data   (req.data1),
        .amount (req.data2),
        .result (shift_res)
    );

    alu_multiplier #(
        .DATA_WIDTH (DATA_WIDTH)
    ) mult0 (
        .data1   (req.data1),
        .data2   (req.data2),
        .product (mul_res)
    );

    always_comb begin
        unique case (req.op)
            op_mov:                 result = req.data2;
            op_add:                 result = sum;
            op_and:                 result = req.data1 & req.data2;
            op_or:                  result = req.data1 | req.data2;
            op_mul:                 result = mul_res;
            op_lsh, op_ash, op_rot: result = shift_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= req.valid;
        end
    end

    // Zero flag follows the adder for every opcode
    always_ff @(posedge clk) begin
        if (req.valid) begin
            res_data <= result;
            res_zero <= (sum == '0);
        end
    end

endmodule

// ==== alu_result_queue.sv ====
`timescale 1ns/10ps

module alu_result_queue #(
    parameter int DATA_WIDTH  = alu_pkg::DEFAULT_DATA_WIDTH,
    parameter int QUEUE_DEPTH = alu_pkg::DEFAULT_QUEUE_DEPTH,
    parameter int OUT_CREDITS = alu_pkg::DEFAULT_OUT_CREDITS
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  res_valid,
    input  logic [DATA_WIDTH-1:0] res_data,
    input  logic                  res_zero,
    input  logic                  out_credit,
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_zero,
    output logic                  in_credit
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    logic [DATA_WIDTH-1:0] mem_data [QUEUE_DEPTH];
    logic                  mem_zero [QUEUE_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic [CRD_W-1:0]      credits;
    logic                  pop;

    // Circular pointer step for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Oldest entry leaves once a consumer credit is held
    assign pop       = (count != '0) && (credits != '0);
    assign out_valid = pop;
    assign out_data  = mem_data[rd_ptr];
    assign out_zero  = mem_zero[rd_ptr];
    // Freed slot goes straight back to the requester
    assign in_credit = pop;

    always_ff @(posedge clk) begin
        if (res_valid) begin
            mem_data[wr_ptr] <= res_data;
            mem_zero[wr_ptr] <= res_zero;
        end
    end

    // Requester credits keep the queue from overflowing
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRD_W'(OUT_CREDITS);
        end else begin
            if (res_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count   <= count + CNT_W'(res_valid) - CNT_W'(pop);
            credits <= credits + CRD_W'(out_credit) - CRD_W'(pop);
        end
    end

endmodule

// ==== alu_top.sv ====
`timescale 1ns/10ps

module alu_top #(
    parameter int DATA_WIDTH  = alu_pkg::DEFAULT_DATA_WIDTH,
    parameter int QUEUE_DEPTH = alu_pkg::DEFAULT_QUEUE_DEPTH,
    parameter int OUT_CREDITS = alu_pkg::DEFAULT_OUT_CREDITS
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  alu_pkg::alu_op_t      in_op,
    input  logic [DATA_WIDTH-1:0] in_data1,
    input  logic [DATA_WIDTH-1:0] in_data2,
    input  logic                  out_credit,
    output logic                  in_credit,
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_zero
);

    logic                  res_valid;
    logic [DATA_WIDTH-1:0] res_data;
    logic                  res_zero;

    alu_req_if #(.DATA_WIDTH(DATA_WIDTH)) req_bus ();

    assign req_bus.valid = in_valid;
    assign req_bus.op    = in_op;
    assign req_bus.data1 = in_data1;
    assign req_bus.data2 = in_data2;

    alu_execute #(
        .DATA_WIDTH (DATA_WIDTH)
    ) exec0 (
        .clk       (clk),
        .reset     (reset),
        .req       (req_bus),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_zero  (res_zero)
    );

    alu_result_queue #(
        .DATA_WIDTH  (DATA_WIDTH),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) queue0 (
        .clk        (clk),
        .reset      (reset),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_zero   (res_zero),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_zero   (out_zero),
        .in_credit  (in_credit)
    );

endmodule

// ==== tb_alu_model.svh ====
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// Negative amount shifts right by its magnitude
function automatic logic [DATA_WIDTH-1:0] model_shift(input alu_op_t op,
        input logic [DATA_WIDTH-1:0] d, input logic [DATA_WIDTH-1:0] amt);
    int n;
    int k;
    n = $signed(amt);
    k = ((n < 0) ? -n : n) % DATA_WIDTH;
    if (op == op_rot) begin
        if (n < 0) begin
            return (d >> k) | (d << ((DATA_WIDTH - k) % DATA_WIDTH));
        end
        return (d << k) | (d >> ((DATA_WIDTH - k) % DATA_WIDTH));
    end
    // Out-of-range amounts saturate
    if (n <= -DATA_WIDTH) begin
        return (op == op_ash) ? {DATA_WIDTH{d[DATA_WIDTH-1]}} : '0;
    end
    if (n >= DATA_WIDTH) begin
        return (op == op_ash) ? {d[DATA_WIDTH-1], {(DATA_WIDTH-1){1'b0}}} : '0;
    end
    if (op == op_ash) begin
        if (n < 0) begin
            return $signed(d) >>> -n;
        end
        return {d[DATA_WIDTH-1], d[DATA_WIDTH-2:0] << n};
    end
    return (n < 0) ? (d >> -n) : (d << n);
endfunction

function automatic logic [DATA_WIDTH-1:0] model_result(input alu_op_t op,
        input logic [DATA_WIDTH-1:0] d1, input logic [DATA_WIDTH-1:0] d2);
    case (op)
        op_mov:  return d2;
        op_add:  return d1 + d2;
        op_and:  return d1 & d2;
        op_or:   return d1 | d2;
        op_mul:  return d1 * d2;
        default: return model_shift(op, d1, d2);
    endcase
endfunction

// Set when data1 plus data2 wraps to zero for any opcode
function automatic logic model_zero(input logic [DATA_WIDTH-1:0] d1,
        input logic [DATA_WIDTH-1:0] d2);
    logic [DATA_WIDTH-1:0] sum;
    sum = d1 + d2;
    return sum == '0;
endfunction

`endif

// ==== tb_alu_top.sv ====
`timescale 1ns/10ps

module tb_alu_top;
    import alu_pkg::*;

    localparam int DATA_WIDTH  = DEFAULT_DATA_WIDTH;
    localparam int QUEUE_DEPTH = DEFAULT_QUEUE_DEPTH;
    localparam int OUT_CREDITS = DEFAULT_OUT_CREDITS;
    localparam int NUM_TESTS   = 5;

    `include "tb_alu_model.svh"

    logic clk;
    logic reset;
    logic in_valid;
    alu_op_t in_op;
    logic [DATA_WIDTH-1:0] in_data1;
    logic [DATA_WIDTH-1:0] in_data2;
    logic out_credit;
    logic in_credit;
    logic out_valid;
    logic [DATA_WIDTH-1:0] out_data;
    logic out_zero;

    logic [DATA_WIDTH-1:0] exp_data[$];
    logic exp_zero[$];
    string cur_test = "reset";
    int in_creds = QUEUE_DEPTH;
    int out_creds = OUT_CREDITS;
    int n_out = 0;
    int cycle = 0;
    int last_in_cycle = 0;
    int last_out_cycle = 0;
    logic auto_credit = 1'b1;
    logic saw_valid = 1'b0;

    alu_top #(
        .DATA_WIDTH  (DATA_WIDTH),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_data1   (in_data1),
        .in_data2   (in_data2),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_zero   (out_zero)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle++;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input logic [DATA_WIDTH-1:0] exp, input logic [DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s data: expected %h, actual %h",
                cur_test, exp, act));
        end
    endtask

    task automatic check_zero(input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s zero: expected %b, actual %b",
                cur_test, exp, act));
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("CHECK FAILED %s %s: expected %0d, actual %0d",
                cur_test, what, exp, act));
        end
    endtask

    // Consumer side compares every result in arrival order
    always @(negedge clk) begin
        if (!reset) begin
            if (in_credit !== out_valid) begin
                abort_run("in_credit did not pulse in the same cycle as out_valid");
            end
            if (in_credit) in_creds++;
            saw_valid = out_valid;
            if (out_valid) begin
                if (out_creds == 0) abort_run("out_valid asserted while no credit was held");
                if (exp_data.size() == 0) abort_run("result arrived with no request outstanding");
                out_creds--;
                check_data(exp_data.pop_front(), out_data);
                check_zero(exp_zero.pop_front(), out_zero);
                n_out++;
                last_out_cycle = cycle;
            end
        end
    end

    // Returns one credit the cycle after each result
    always @(posedge clk) begin
        #1;
        if (auto_credit) begin
            out_credit = saw_valid;
            if (saw_valid) out_creds++;
        end
    end

    task automatic send(input alu_op_t op, input logic [DATA_WIDTH-1:0] d1,
            input logic [DATA_WIDTH-1:0] d2);
        while (in_creds == 0) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_op    = op;
        in_data1 = d1;
        in_data2 = d2;
        in_creds--;
        exp_data.push_back(model_result(op, d1, d2));
        exp_zero.push_back(model_zero(d1, d2));
        last_in_cycle = cycle;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 40) abort_run($sformatf("%s: no result arrived in time", cur_test));
        end
    endtask

    task automatic test_reset_latency();
        cur_test = "reset_latency";
        repeat (5) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
                abort_run("out_valid or in_credit active after reset with no request");
            end
        end
        @(posedge clk);
        #1;
        send(op_add, 8'h2c, 8'h17);
        wait_drain();
        check_count("latency", 2, last_out_cycle - last_in_cycle);
    endtask

    task automatic test_all_ops();
        logic [DATA_WIDTH-1:0] a [6];
        logic [DATA_WIDTH-1:0] b [6];
        cur_test = "all_ops";
        a = '{8'h00, 8'hff, 8'h80, 8'h7f, 8'ha5, 8'h10};
        b = '{8'h00, 8'h01, 8'h80, 8'h81, 8'h5a, 8'hf0};
        for (int k = 0; k <= 4; k++) begin
            for (int i = 0; i < 6; i++) send(alu_op_t'(k), a[i], b[i]);
        end
        // Subtraction through the two's complement of data2
        for (int i = 0; i < 6; i++) send(op_add, a[i], ~b[i] + 1'b1);
        for (int i = 0; i < 50; i++) begin
            send(alu_op_t'($urandom_range(0, 7)), DATA_WIDTH'($urandom), DATA_WIDTH'($urandom));
        end
        wait_drain();
    endtask

    task automatic test_shifts();
        logic [DATA_WIDTH-1:0] amt [10];
        logic [DATA_WIDTH-1:0] dat [4];
        cur_test = "shifts";
        amt = '{8'h00, 8'h01, 8'hff, 8'h03, 8'hfd, 8'h07, 8'hf9, 8'h08, 8'hf8, 8'h80};
        dat = '{8'h96, 8'h5b, 8'h80, 8'h01};
        for (int k = 5; k <= 7; k++) begin
            foreach (dat[d]) begin
                foreach (amt[s]) send(alu_op_t'(k), dat[d], amt[s]);
            end
        end
        wait_drain();
    endtask

    task automatic test_zero_flag();
        logic [DATA_WIDTH-1:0] a [5];
        logic [DATA_WIDTH-1:0] b [5];
        cur_test = "zero_flag";
        a = '{8'h37, 8'h00, 8'h37, 8'h80, 8'h01};
        b = '{8'hc9, 8'h00, 8'hc8, 8'h80, 8'h00};
        for (int k = 0; k <= 7; k++) begin
            for (int i = 0; i < 5; i++) send(alu_op_t'(k), a[i], b[i]);
        end
        wait_drain();
    endtask

    task automatic test_back_pressure();
        int base;
        cur_test = "back_pressure";
        wait_drain();
        // Let the last automatic credit land before taking over
        repeat (2) @(negedge clk);
        auto_credit = 1'b0;
        @(posedge clk);
        #1;
        out_credit = 1'b0;
        base = n_out;
        for (int i = 0; i < QUEUE_DEPTH; i++) send(op_add, DATA_WIDTH'($urandom), DATA_WIDTH'(i));
        repeat (10) @(posedge clk);
        #1;
        check_count("results without returned credits", OUT_CREDITS, n_out - base);
        check_count("input credits held", OUT_CREDITS, in_creds);
        for (int i = 0; i < QUEUE_DEPTH - OUT_CREDITS; i++) begin
            base = n_out;
            out_credit = 1'b1;
            out_creds++;
            @(posedge clk);
            #1;
            out_credit = 1'b0;
            repeat (4) @(posedge clk);
            #1;
            check_count("results per returned credit", 1, n_out - base);
        end
    endtask

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        abort_run("watchdog timeout, the tests did not complete in time");
    end

    initial begin
        void'($urandom(32'hf52f_7379));
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_op      = op_mov;
        in_data1   = '0;
        in_data2   = '0;
        out_credit = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_latency();
        test_all_ops();
        test_shifts();
        test_zero_flag();
        test_back_pressure();
        if (exp_data.size() != 0) begin
            abort_run("results still outstanding at the end of the run");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+.
alu_pkg.sv
alu_req_if.sv
alu_shifter.sv
alu_multiplier.sv
alu_execute.sv
alu_result_queue.sv
alu_top.sv
tb_alu_top.sv
